// File: sim.f
agg_pkg.sv
ingress_fifo.sv
agg_sequencer.sv
lane_reduce.sv
agg_egress.sv
agg_top.sv
tb_clock_gen.sv
agg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the reduction datapath testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module agg_tb -f sim.f -o agg_sim \
  && ./obj_dir/agg_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1

// File: agg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module agg_tb;
  import agg_pkg::*;

  localparam int          NUM_PKTS   = 6;
  localparam int          HDR_BEATS  = 5;
  localparam int          MAX_BEATS  = 16;
  localparam int          SEED       = 74;
  localparam int          CYC_PER_BT = 40;   // watchdog budget per beat
  localparam logic [3:0]  EN_MASK    = 4'b1100;
  localparam logic [47:0] NEW_MAC    = 48'hffff_ffff_ffff;

  typedef struct packed {
    int   payload;    // payload beats after the header
    int   skew;       // port 3 delay in cycles
    int   ready_pct;  // egress tready duty, 100 = always
    logic junk;       // extra traffic on port 0
  } pkt_cfg_t;

  logic                  axis_aclk;
  logic                  axis_resetn;
  logic [DATA_WIDTH-1:0] s_tdata [NUM_PORTS];
  logic [KEEP_WIDTH-1:0] s_tkeep [NUM_PORTS];
  logic [NUM_PORTS-1:0]  s_tvalid;
  logic [NUM_PORTS-1:0]  s_tlast;
  wire  [NUM_PORTS-1:0]  s_tready;
  wire  [DATA_WIDTH-1:0] m_tdata [NUM_PORTS];
  wire  [KEEP_WIDTH-1:0] m_tkeep [NUM_PORTS];
  wire  [NUM_PORTS-1:0]  m_tvalid;
  wire  [NUM_PORTS-1:0]  m_tlast;
  logic [NUM_PORTS-1:0]  m_tready;

  pkt_cfg_t   pkt_table [NUM_PKTS];
  axis_beat_t pkt [NUM_PORTS][MAX_BEATS];  // stimulus per port
  axis_beat_t exp_beats [MAX_BEATS];       // expected egress sequence
  int         exp_count;
  int         rx_cnt [NUM_PORTS];
  int         cur_pkt;
  int         cur_ready_pct;
  int         error_count;
  int         check_count;
  int         watchdog_cycles;

  tb_clock_gen #(.period_ns(8), .reset_cycles(2)) u_clk (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn)
  );

  agg_top dut0 (
    .axis_aclk       (axis_aclk),
    .axis_resetn     (axis_resetn),
    .s_axis_0_tdata  (s_tdata[0]),
    .s_axis_0_tkeep  (s_tkeep[0]),
    .s_axis_0_tvalid (s_tvalid[0]),
    .s_axis_0_tlast  (s_tlast[0]),
    .s_axis_0_tready (s_tready[0]),
    .s_axis_1_tdata  (s_tdata[1]),
    .s_axis_1_tkeep  (s_tkeep[1]),
    .s_axis_1_tvalid (s_tvalid[1]),
    .s_axis_1_tlast  (s_tlast[1]),
    .s_axis_1_tready (s_tready[1]),
    .s_axis_2_tdata  (s_tdata[2]),
    .s_axis_2_tkeep  (s_tkeep[2]),
    .s_axis_2_tvalid (s_tvalid[2]),
    .s_axis_2_tlast  (s_tlast[2]),
    .s_axis_2_tready (s_tready[2]),
    .s_axis_3_tdata  (s_tdata[3]),
    .s_axis_3_tkeep  (s_tkeep[3]),
    .s_axis_3_tvalid (s_tvalid[3]),
    .s_axis_3_tlast  (s_tlast[3]),
    .s_axis_3_tready (s_tready[3]),
    .m_axis_0_tdata  (m_tdata[0]),
    .m_axis_0_tkeep  (m_tkeep[0]),
    .m_axis_0_tvalid (m_tvalid[0]),
    .m_axis_0_tlast  (m_tlast[0]),
    .m_axis_0_tready (m_tready[0]),
    .m_axis_1_tdata  (m_tdata[1]),
    .m_axis_1_tkeep  (m_tkeep[1]),
    .m_axis_1_tvalid (m_tvalid[1]),
    .m_axis_1_tlast  (m_tlast[1]),
    .m_axis_1_tready (m_tready[1]),
    .m_axis_2_tdata  (m_tdata[2]),
    .m_axis_2_tkeep  (m_tkeep[2]),
    .m_axis_2_tvalid (m_tvalid[2]),
    .m_axis_2_tlast  (m_tlast[2]),
    .m_axis_2_tready (m_tready[2]),
    .m_axis_3_tdata  (m_tdata[3]),
    .m_axis_3_tkeep  (m_tkeep[3]),
    .m_axis_3_tvalid (m_tvalid[3]),
    .m_axis_3_tlast  (m_tlast[3]),
    .m_axis_3_tready (m_tready[3])
  );

  task automatic check_value(input string sig, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error: time %0t signal %s actual 0x%0h expected 0x%0h",
               $time, sig, actual, expected);
    end
  endtask

  task automatic load_table();
    // payload, skew, ready duty, junk on port 0
    pkt_table[0] = '{1, 0, 100, 1'b0};
    pkt_table[1] = '{3, 2, 100, 1'b1};
    pkt_table[2] = '{6, 0, 50, 1'b0};
    pkt_table[3] = '{2, 5, 30, 1'b1};
    pkt_table[4] = '{5, 1, 70, 1'b1};
    pkt_table[5] = '{4, 3, 40, 1'b0};
  endtask

  // stimulus for ports 2, 3 and 0 plus the expected egress beats
  task automatic build_packet(input pkt_cfg_t cfg, output int nbeats, output int junk_n);
    logic [63:0] w;
    logic [63:0] d2;
    logic [63:0] d3;
    logic [7:0]  k2;
    logic [31:0] lo;
    logic [31:0] hi;
    logic        last;
    nbeats = HDR_BEATS + cfg.payload;
    for (int b = 0; b < HDR_BEATS; b++) begin
      w = {$urandom, $urandom};
      pkt[2][b] = '{tdata: w, tkeep: 8'hff, tlast: 1'b0};
      pkt[3][b] = pkt[2][b];  // headers match on all ports
      exp_beats[b] = pkt[2][b];
      if (b == 0) begin
        exp_beats[b].tdata = {w[63:48], NEW_MAC};
      end
    end
    for (int b = HDR_BEATS; b < nbeats; b++) begin
      last = (b == nbeats - 1);
      d2   = {$urandom, $urandom};
      d3   = {$urandom, $urandom};
      k2   = last ? 8'($urandom_range(255, 1)) : 8'hff;
      pkt[2][b] = '{tdata: d2, tkeep: k2, tlast: last};
      pkt[3][b] = '{tdata: d3, tkeep: 8'hff, tlast: last};  // keep differs from master
      lo = d2[31:0] + d3[31:0];    // wraps mod 2^32
      hi = d2[63:32] + d3[63:32];
      exp_beats[b] = '{tdata: {hi, lo}, tkeep: k2, tlast: last};
    end
    junk_n = cfg.junk ? int'($urandom_range(4, 1)) : 0;
    for (int b = 0; b < junk_n; b++) begin
      pkt[0][b] = '{tdata: {$urandom, $urandom}, tkeep: 8'hff, tlast: (b == junk_n - 1)};
    end
    exp_count = nbeats;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rx_cnt[p] = 0;
    end
  endtask

  task automatic drive_port(input int p, input int nbeats, input int delay);
    repeat (delay) @(posedge axis_aclk);
    for (int b = 0; b < nbeats; b++) begin
      s_tdata[p]  <= pkt[p][b].tdata;
      s_tkeep[p]  <= pkt[p][b].tkeep;
      s_tlast[p]  <= pkt[p][b].tlast;
      s_tvalid[p] <= 1'b1;
      do begin
        @(negedge axis_aclk);
      end while (!s_tready[p]);
      @(posedge axis_aclk);  // transfer on this edge
    end
    s_tvalid[p] <= 1'b0;
  endtask

  // random egress back-pressure
  always @(posedge axis_aclk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      m_tready[p] <= (cur_ready_pct >= 100) ? 1'b1 :
                     (int'($urandom_range(99)) < cur_ready_pct);
    end
  end

  // scoreboard samples mid-cycle where everything is stable
  always @(negedge axis_aclk) begin
    if (axis_resetn) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (!EN_MASK[p]) begin
          if (m_tvalid[p]) begin
            error_count++;
            $display("packet %0d: tvalid raised on disabled egress port %0d", cur_pkt, p);
          end
        end else if (m_tvalid[p] && m_tready[p]) begin
          if (rx_cnt[p] >= exp_count) begin
            error_count++;
            $display("packet %0d: egress port %0d delivered more beats than expected",
                     cur_pkt, p);
          end else begin
            check_value($sformatf("m_axis_%0d_tdata[%0d]", p, rx_cnt[p]),
                        m_tdata[p], exp_beats[rx_cnt[p]].tdata);
            check_value($sformatf("m_axis_%0d_tkeep[%0d]", p, rx_cnt[p]),
                        64'(m_tkeep[p]), 64'(exp_beats[rx_cnt[p]].tkeep));
            check_value($sformatf("m_axis_%0d_tlast[%0d]", p, rx_cnt[p]),
                        64'(m_tlast[p]), 64'(exp_beats[rx_cnt[p]].tlast));
            rx_cnt[p]++;
          end
        end
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge axis_aclk);
    $display("watchdog: run did not finish within %0d cycles, stuck in packet %0d",
             watchdog_cycles, cur_pkt);
    $display("Test failed");
    $finish;
  end

  initial begin
    int total_beats;
    int nbeats;
    int junk_n;
    int errs_before;
    pkt_cfg_t cfg;
    void'($urandom(SEED));
    s_tvalid      = '0;
    s_tlast       = '0;
    m_tready      = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      s_tdata[p] = '0;
      s_tkeep[p] = '0;
      rx_cnt[p]  = 0;
    end
    cur_pkt       = 0;
    cur_ready_pct = 100;
    error_count   = 0;
    check_count   = 0;
    exp_count     = 0;
    load_table();
    total_beats = 0;
    for (int i = 0; i < NUM_PKTS; i++) begin
      total_beats += HDR_BEATS + pkt_table[i].payload;
    end
    watchdog_cycles = total_beats * CYC_PER_BT;

    wait (axis_resetn === 1'b1);
    @(posedge axis_aclk);
    for (int i = 0; i < NUM_PKTS; i++) begin
      cfg         = pkt_table[i];
      cur_pkt     = i;
      errs_before = error_count;
      build_packet(cfg, nbeats, junk_n);
      cur_ready_pct <= cfg.ready_pct;
      fork
        drive_port(2, nbeats, 0);
        drive_port(3, nbeats, cfg.skew);
        drive_port(0, junk_n, 1);
      join
      while (rx_cnt[2] < exp_count || rx_cnt[3] < exp_count) begin
        @(posedge axis_aclk);
      end
      repeat (4) @(posedge axis_aclk);  // catch any repeated beat
      $display("packet %0d: payload %0d skew %0d ready %0d%% junk %0d beats %0d errors %0d",
               i, cfg.payload, cfg.skew, cfg.ready_pct, junk_n, nbeats,
               error_count - errs_before);
    end
    repeat (5) @(posedge axis_aclk);
    $display("packets %0d checks %0d errors %0d", NUM_PKTS, check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 2
) (
  output logic axis_aclk,
  output logic axis_resetn
);

  initial begin
    axis_aclk = 1'b0;
    forever #(period_ns / 2) axis_aclk = ~axis_aclk;
  end

  // release on a rising edge, reset is synchronous
  initial begin
    axis_resetn = 1'b0;
    repeat (reset_cycles) @(posedge axis_aclk);
    axis_resetn <= 1'b1;
  end

endmodule

`default_nettype wire

// File: agg_top.sv
`timescale 1ns/1ns
`default_nettype none

module agg_top #(
  parameter agg_pkg::port_mask_t           port_mask       = 4'b1100,
  parameter int                            master_port     = 2,
  parameter logic [agg_pkg::MAC_WIDTH-1:0] new_dest_mac    = '1,
  parameter int                            header_beats    = 5,
  parameter int                            fifo_depth_bits = 4
) (
  input  logic                             axis_aclk,
  input  logic                             axis_resetn,
  input  logic [agg_pkg::DATA_WIDTH-1:0]   s_axis_0_tdata,
  input  logic [agg_pkg::KEEP_WIDTH-1:0]   s_axis_0_tkeep,
  input  logic                             s_axis_0_tvalid,
  input  logic                             s_axis_0_tlast,
  output logic                             s_axis_0_tready,
  input  logic [agg_pkg::DATA_WIDTH-1:0]   s_axis_1_tdata,
  input  logic [agg_pkg::KEEP_WIDTH-1:0]   s_axis_1_tkeep,
  input  logic                             s_axis_1_tvalid,
  input  logic                             s_axis_1_tlast,
  output logic                             s_axis_1_tready,
  input  logic [agg_pkg::DATA_WIDTH-1:0]   s_axis_2_tdata,
  input  logic [agg_pkg::KEEP_WIDTH-1:0]   s_axis_2_tkeep,
  input  logic                             s_axis_2_tvalid,
  input  logic                             s_axis_2_tlast,
  output logic                             s_axis_2_tready,
  input  logic [agg_pkg::DATA_WIDTH-1:0]   s_axis_3_tdata,
  input  logic [agg_pkg::KEEP_WIDTH-1:0]   s_axis_3_tkeep,
  input  logic                             s_axis_3_tvalid,
  input  logic                             s_axis_3_tlast,
  output logic                             s_axis_3_tready,
  output logic [agg_pkg::DATA_WIDTH-1:0]   m_axis_0_tdata,
  output logic [agg_pkg::KEEP_WIDTH-1:0]   m_axis_0_tkeep,
  output logic                             m_axis_0_tvalid,
  output logic                             m_axis_0_tlast,
  input  logic                             m_axis_0_tready,
  output logic [agg_pkg::DATA_WIDTH-1:0]   m_axis_1_tdata,
  output logic [agg_pkg::KEEP_WIDTH-1:0]   m_axis_1_tkeep,
  output logic                             m_axis_1_tvalid,
  output logic                             m_axis_1_tlast,
  input  logic                             m_axis_1_tready,
  output logic [agg_pkg::DATA_WIDTH-1:0]   m_axis_2_tdata,
  output logic [agg_pkg::KEEP_WIDTH-1:0]   m_axis_2_tkeep,
  output logic                             m_axis_2_tvalid,
  output logic                             m_axis_2_tlast,
  input  logic                             m_axis_2_tready,
  output logic [agg_pkg::DATA_WIDTH-1:0]   m_axis_3_tdata,
  output logic [agg_pkg::KEEP_WIDTH-1:0]   m_axis_3_tkeep,
  output logic                             m_axis_3_tvalid,
  output logic                             m_axis_3_tlast,
  input  logic                             m_axis_3_tready
);
  import agg_pkg::*;

  axis_beat_t [NUM_PORTS-1:0]                 s_beat;
  port_mask_t                                 s_valid;
  port_mask_t                                 s_ready;
  axis_beat_t [NUM_PORTS-1:0]                 heads;
  port_mask_t                                 empties;
  port_mask_t                                 pops;
  reduce_req_t                                req;
  logic                                       req_valid;
  logic                                       req_ready;
  axis_beat_t                                 res;
  logic                                       res_valid;
  logic                                       res_ready;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]       m_tdata;
  logic [NUM_PORTS-1:0][KEEP_WIDTH-1:0]       m_tkeep;
  logic [NUM_PORTS-1:0]                       m_tlast;
  port_mask_t                                 m_tvalid;
  port_mask_t                                 m_tready;

  // flat ingress ports into beats
  assign s_beat[0] = '{tdata: s_axis_0_tdata, tkeep: s_axis_0_tkeep, tlast: s_axis_0_tlast};
  assign s_beat[1] = '{tdata: s_axis_1_tdata, tkeep: s_axis_1_tkeep, tlast: s_axis_1_tlast};
  assign s_beat[2] = '{tdata: s_axis_2_tdata, tkeep: s_axis_2_tkeep, tlast: s_axis_2_tlast};
  assign s_beat[3] = '{tdata: s_axis_3_tdata, tkeep: s_axis_3_tkeep, tlast: s_axis_3_tlast};
  assign s_valid   = {s_axis_3_tvalid, s_axis_2_tvalid, s_axis_1_tvalid, s_axis_0_tvalid};
  assign {s_axis_3_tready, s_axis_2_tready, s_axis_1_tready, s_axis_0_tready} = s_ready;

  // egress arrays back out to flat ports
  assign {m_axis_3_tdata, m_axis_2_tdata, m_axis_1_tdata, m_axis_0_tdata}     = m_tdata;
  assign {m_axis_3_tkeep, m_axis_2_tkeep, m_axis_1_tkeep, m_axis_0_tkeep}     = m_tkeep;
  assign {m_axis_3_tlast, m_axis_2_tlast, m_axis_1_tlast, m_axis_0_tlast}     = m_tlast;
  assign {m_axis_3_tvalid, m_axis_2_tvalid, m_axis_1_tvalid, m_axis_0_tvalid} = m_tvalid;
  assign m_tready = {m_axis_3_tready, m_axis_2_tready, m_axis_1_tready, m_axis_0_tready};

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ingress
    ingress_fifo #(
      .depth_bits (fifo_depth_bits)
    ) u_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .in_beat     (s_beat[p]),
      .in_valid    (s_valid[p]),
      .in_ready    (s_ready[p]),
      .head        (heads[p]),
      .empty       (empties[p]),
      .pop         (pops[p])
    );
  end

  agg_sequencer #(
    .port_mask    (port_mask),
    .master_port  (master_port),
    .new_dest_mac (new_dest_mac),
    .header_beats (header_beats)
  ) u_seq (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .heads       (heads),
    .empties     (empties),
    .pops        (pops),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready)
  );

  lane_reduce #(
    .port_mask (port_mask)
  ) u_reduce (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .res         (res),
    .res_valid   (res_valid),
    .res_ready   (res_ready)
  );

  agg_egress #(
    .port_mask (port_mask)
  ) u_egress (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .res         (res),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .m_tdata     (m_tdata),
    .m_tkeep     (m_tkeep),
    .m_tlast     (m_tlast),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready)
  );

endmodule

`default_nettype wire

// File: agg_egress.sv
`timescale 1ns/1ns
`default_nettype none

module agg_egress #(
  parameter agg_pkg::port_mask_t port_mask = 4'b1100
) (
  input  logic                                                   axis_aclk,
  input  logic                                                   axis_resetn,
  input  agg_pkg::axis_beat_t                                    res,
  input  logic                                                   res_valid,
  output logic                                                   res_ready,
  output logic [agg_pkg::NUM_PORTS-1:0][agg_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic [agg_pkg::NUM_PORTS-1:0][agg_pkg::KEEP_WIDTH-1:0] m_tkeep,
  output logic [agg_pkg::NUM_PORTS-1:0]                          m_tlast,
  output agg_pkg::port_mask_t                                    m_tvalid,
  input  agg_pkg::port_mask_t                                    m_tready
);
  import agg_pkg::*;

  axis_beat_t beat;      // beat being broadcast
  logic       full;
  port_mask_t done;      // enabled ports that already took the beat
  port_mask_t xfer;
  logic       all_done;

  assign m_tvalid  = full ? (port_mask & ~done) : '0;
  assign xfer      = m_tvalid & m_tready;
  assign all_done  = (((done | xfer) & port_mask) == port_mask);
  assign res_ready = !full || all_done;  // reload once the last port completes

  // same beat on every port, tvalid picks who sees it
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      m_tdata[p] = beat.tdata;
      m_tkeep[p] = beat.tkeep;
      m_tlast[p] = beat.tlast;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (res_ready && res_valid) begin
      beat <= res;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      full <= 1'b0;
      done <= '0;
    end else if (res_ready) begin
      full <= res_valid;
      done <= '0;
    end else begin
      done <= done | xfer;
    end
  end

  // an offered beat stays put until its port takes it
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_hold_chk
    a_hold: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      (m_tvalid[p] && !m_tready[p]) |=> (m_tvalid[p] && $stable(m_tdata[p])))
      else $error("agg_egress: port %0d changed an unaccepted beat", p);
  end

endmodule

`default_nettype wire

// File: lane_reduce.sv
`timescale 1ns/1ns
`default_nettype none

module lane_reduce #(
  parameter agg_pkg::port_mask_t port_mask = 4'b1100
) (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  agg_pkg::reduce_req_t req,
  input  logic                 req_valid,
  output logic                 req_ready,
  output agg_pkg::axis_beat_t  res,
  output logic                 res_valid,
  input  logic                 res_ready
);
  import agg_pkg::*;

  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_sum;
  axis_beat_t                           next_beat;
  logic                                 take;

  assign req_ready = !res_valid || res_ready;  // empty, or leaving this cycle
  assign take      = req_valid && req_ready;

  // integer sum per lane, wraps mod 2^32
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_sum[l] = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_mask[p]) begin
          lane_sum[l] = lane_sum[l] + get_lane(req.beats[p].tdata, l);
        end
      end
    end
  end

  always_comb begin
    if (req.is_header) begin
      next_beat = req.master;  // header passes through
    end else begin
      next_beat.tdata = lane_sum;
      next_beat.tkeep = req.master.tkeep;
      next_beat.tlast = req.master.tlast;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (take) begin
      res <= next_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      res_valid <= 1'b0;
    end else if (take) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: agg_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module agg_sequencer #(
  parameter agg_pkg::port_mask_t           port_mask    = 4'b1100,
  parameter int                            master_port  = 2,
  parameter logic [agg_pkg::MAC_WIDTH-1:0] new_dest_mac = '1,
  parameter int                            header_beats = 5
) (
  input  logic                                         axis_aclk,
  input  logic                                         axis_resetn,
  input  agg_pkg::axis_beat_t [agg_pkg::NUM_PORTS-1:0] heads,
  input  agg_pkg::port_mask_t                          empties,
  output agg_pkg::port_mask_t                          pops,
  output agg_pkg::reduce_req_t                         req,
  output logic                                         req_valid,
  input  logic                                         req_ready
);
  import agg_pkg::*;

  localparam int CNT_W = (header_beats > 1) ? $clog2(header_beats) : 1;

  logic             in_header;  // header phase
  logic [CNT_W-1:0] hdr_cnt;    // header beat index in packet
  logic             all_avail;
  logic             lock_pop;
  logic             last_hdr;
  port_mask_t       tlasts;
  axis_beat_t       master_beat;

  assign all_avail = ((~empties & port_mask) == port_mask);
  assign lock_pop  = all_avail && req_ready;
  assign last_hdr  = (hdr_cnt == CNT_W'(header_beats - 1));

  // enabled ports move together, the rest are drained as they fill
  assign pops      = (lock_pop ? port_mask : '0) | (~empties & ~port_mask);
  assign req_valid = lock_pop;  // reducer is ready, so taken this cycle

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      tlasts[p] = heads[p].tlast;
    end
  end

  // mac rewrite only touches the first header beat
  always_comb begin
    master_beat = heads[master_port];
    if (in_header && hdr_cnt == '0) begin
      master_beat.tdata = set_dest_mac(master_beat.tdata, new_dest_mac);
    end
  end

  assign req.beats     = heads;
  assign req.is_header = in_header;
  assign req.master    = master_beat;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      in_header <= 1'b1;
      hdr_cnt   <= '0;
    end else if (lock_pop) begin
      if (in_header) begin
        if (last_hdr) begin
          in_header <= 1'b0;  // payload follows
          hdr_cnt   <= '0;
        end else begin
          hdr_cnt <= hdr_cnt + 1'b1;
        end
      end else if (master_beat.tlast) begin
        in_header <= 1'b1;    // next packet starts with its header
      end
    end
  end

  // a packet must be longer than its header on every enabled port
  a_no_tlast_in_header: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    (lock_pop && in_header) |-> ((tlasts & port_mask) == '0))
    else $error("agg_sequencer: tlast inside header phase");

endmodule

`default_nettype wire

// File: ingress_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module ingress_fifo #(
  parameter int depth_bits = 4
) (
  input  logic                axis_aclk,
  input  logic                axis_resetn,
  input  agg_pkg::axis_beat_t in_beat,
  input  logic                in_valid,
  output logic                in_ready,
  output agg_pkg::axis_beat_t head,
  output logic                empty,
  input  logic                pop
);
  import agg_pkg::*;

  localparam int DEPTH = 2 ** depth_bits;

  axis_beat_t          mem [DEPTH];
  logic [depth_bits:0] wr_ptr;  // extra msb tells full from empty
  logic [depth_bits:0] rd_ptr;
  logic                full;
  logic                wr_en;

  assign full     = (wr_ptr[depth_bits] != rd_ptr[depth_bits]) &&
                    (wr_ptr[depth_bits-1:0] == rd_ptr[depth_bits-1:0]);
  assign empty    = (wr_ptr == rd_ptr);
  assign in_ready = !full;
  assign wr_en    = in_valid && !full;

  // fall-through head
  assign head = mem[rd_ptr[depth_bits-1:0]];

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr[depth_bits-1:0]] <= in_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // the sequencer only pops what the fifo presents
  a_no_pop_empty: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    pop |-> !empty)
    else $error("ingress_fifo: pop while empty");

endmodule

`default_nettype wire

// File: agg_pkg.sv
`default_nettype none

package agg_pkg;

  localparam int NUM_PORTS    = 4;
  localparam int DATA_WIDTH   = 64;
  localparam int KEEP_WIDTH   = DATA_WIDTH / 8;
  localparam int LANE_WIDTH   = 32;
  localparam int NUM_LANES    = DATA_WIDTH / LANE_WIDTH;
  localparam int MAC_WIDTH    = 48;
  localparam int DEST_MAC_LSB = 0;  // dest mac at the bottom of header beat 0

  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // one stream beat
  typedef struct packed {
    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tlast;
  } axis_beat_t;

  // lock-step request from sequencer to reducer
  typedef struct packed {
    axis_beat_t [NUM_PORTS-1:0] beats;      // fifo heads, index = port
    logic                       is_header;
    axis_beat_t                 master;     // master beat, mac already rewritten
  } reduce_req_t;

  function automatic logic [LANE_WIDTH-1:0] get_lane(
    input logic [DATA_WIDTH-1:0] data,
    input int                    lane
  );
    return data[lane*LANE_WIDTH +: LANE_WIDTH];
  endfunction

  function automatic logic [DATA_WIDTH-1:0] set_dest_mac(
    input logic [DATA_WIDTH-1:0] data,
    input logic [MAC_WIDTH-1:0]  mac
  );
    logic [DATA_WIDTH-1:0] res;
    res = data;
    res[DEST_MAC_LSB +: MAC_WIDTH] = mac;
    return res;
  endfunction

endpackage

`default_nettype wire
